//--- sim.f
+incdir+include
logic/reg_types_pkg.sv
logic/access_pkg.sv
logic/bank_file.sv
logic/ptr_file.sv
logic/operand_select.sv
logic/regs_top.sv
bench/regs_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/100ps -f sim.f --top-module regs_tb \
    -Mdir obj_dir -o regs_sim \
    && ./obj_dir/regs_sim > sim.log 2>&1 \
    || { echo "build or simulation run did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

//--- bench/regs_tb.sv
// testbench for the general register block with a stimulus/expected table and a check task
`timescale 1ns/100ps

module regs_tb
    import reg_types_pkg::*, access_pkg::*;
();

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int SAMPLE_DLY  = 1;
    localparam int RST_CYCLES  = 16;
    localparam int RST_TIMEOUT = 100;
    localparam int MAX_ROWS    = 48;
    localparam int N_DATA      = 11;

    // which outputs a row checks
    localparam logic [6:0] C_SRC = 7'b0000001;
    localparam logic [6:0] C_AUX = 7'b0000010;
    localparam logic [6:0] C_DST = 7'b0000100;
    localparam logic [6:0] C_XSP = 7'b0001000;
    localparam logic [6:0] C_DMP = 7'b0010000;
    localparam logic [6:0] C_UNI = 7'b0100000;
    localparam logic [6:0] C_RFP = 7'b1000000;
    localparam logic [6:0] C_SD  = C_SRC | C_DST;

    localparam size_t W_BYTE = 3'b001;
    localparam size_t W_WORD = 3'b010;
    localparam size_t W_LONG = 3'b100;

    typedef struct packed {
        logic       hold;
        logic       inc_rfp;
        logic       dec_rfp;
        logic       rfp_we;
        bank_t      imm;
        logic       dec_bc;
        logic       xdehl_dec;
        logic       reg_inc;
        logic       reg_dec;
        step_t      reg_step;
        logic [2:0] inc_xsp;
        logic [2:0] dec_xsp;
        logic       idx_en;
        reg_code_t  idx_rdreg_sel;
        reg_code_t  idx_rdreg_aux;
        reg_code_t  src;
        reg_code_t  dst;
        long_t      alu_dout;
        long_t      ram_dout;
        logic       data_sel;
        logic       flag_only;
        size_t      alu_we;
        size_t      ram_we;
        byte_t      dmp_addr;
        word_t      sr;
        long_t      e_src;
        long_t      e_aux;
        long_t      e_dst;
        long_t      e_xsp;
        byte_t      e_dmp;
        logic       e_unity;
        bank_t      e_rfp;
        logic [6:0] chk;
    } row_t;

    logic       clk, rst, cen;
    logic       inc_rfp, dec_rfp, rfp_we, dec_bc, xdehl_dec, reg_inc, reg_dec;
    logic       idx_en, data_sel, flag_only, bc_unity;
    logic [2:0] inc_xsp, dec_xsp;
    bank_t      imm, rfp;
    step_t      reg_step;
    word_t      sr;
    reg_code_t  src, dst, idx_rdreg_sel, idx_rdreg_aux;
    long_t      alu_dout, ram_dout, src_out, aux_out, dst_out, xsp;
    size_t      alu_we, ram_we;
    byte_t      dmp_addr, dmp_din;

    row_t   tbl [MAX_ROWS];
    row_t   cur;
    int     n_rows;
    int     n_checks;
    int     n_errors;
    integer seed;
    long_t  d [N_DATA];

    regs_top i_regs_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
    end

    task automatic drive_row(input row_t r);
        cen           = ~r.hold;
        inc_rfp       = r.inc_rfp;
        dec_rfp       = r.dec_rfp;
        rfp_we        = r.rfp_we;
        imm           = r.imm;
        dec_bc        = r.dec_bc;
        xdehl_dec     = r.xdehl_dec;
        reg_inc       = r.reg_inc;
        reg_dec       = r.reg_dec;
        reg_step      = r.reg_step;
        inc_xsp       = r.inc_xsp;
        dec_xsp       = r.dec_xsp;
        idx_en        = r.idx_en;
        idx_rdreg_sel = r.idx_rdreg_sel;
        idx_rdreg_aux = r.idx_rdreg_aux;
        src           = r.src;
        dst           = r.dst;
        alu_dout      = r.alu_dout;
        ram_dout      = r.ram_dout;
        data_sel      = r.data_sel;
        flag_only     = r.flag_only;
        alu_we        = r.alu_we;
        ram_we        = r.ram_we;
        dmp_addr      = r.dmp_addr;
        sr            = r.sr;
    endtask

    task automatic check_value(input string what, input int row, input long_t got,
                               input long_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: row %0d %s is %h, expected %h",
                     $time, row, what, got, exp);
        end
    endtask

    task automatic check_row(input int r);
        row_t t;
        t = tbl[r];
        if (t.chk & C_SRC) check_value("src_out", r, src_out, t.e_src);
        if (t.chk & C_AUX) check_value("aux_out", r, aux_out, t.e_aux);
        if (t.chk & C_DST) check_value("dst_out", r, dst_out, t.e_dst);
        if (t.chk & C_XSP) check_value("xsp", r, xsp, t.e_xsp);
        if (t.chk & C_DMP) check_value("dmp_din", r, {24'h0, dmp_din}, {24'h0, t.e_dmp});
        if (t.chk & C_UNI) check_value("bc_unity", r, {31'h0, bc_unity}, {31'h0, t.e_unity});
        if (t.chk & C_RFP) check_value("rfp", r, {30'h0, rfp}, {30'h0, t.e_rfp});
    endtask

    // the path not selected carries inverted data with a long write enable
    task automatic set_write(input long_t data, input size_t size, input logic via_ram);
        cur.data_sel = via_ram;
        if (via_ram) begin
            cur.ram_dout = data;
            cur.ram_we   = size;
            cur.alu_dout = ~data;
            cur.alu_we   = W_LONG;
        end else begin
            cur.alu_dout = data;
            cur.alu_we   = size;
            cur.ram_dout = ~data;
            cur.ram_we   = W_LONG;
        end
    endtask

    task automatic add_row(input reg_code_t s, input reg_code_t dc, input long_t e_src,
                           input long_t e_dst, input logic [6:0] chk);
        cur.src   = s;
        cur.dst   = dc;
        cur.e_src = e_src;
        cur.e_dst = e_dst;
        cur.chk   = cur.chk | chk;
        tbl[n_rows] = cur;
        n_rows++;
        cur = '0;
    endtask

    // expected values follow the outputs one edge after the row is driven
    task automatic build_table();
        long_t xwa0, xiy, xiz, xix;
        for (int i = 0; i < N_DATA; i++) begin
            d[i] = $random(seed);
        end
        xwa0 = {d[0][31:24], d[4][7:0], d[0][15:0]};
        xiy  = {24'h0, d[3][7:0]};
        xiz  = {16'h0, d[5][15:0]};
        xix  = d[1] + 32'd3;
        cur  = '0;
        // sized writes through both paths while rfp is 0
        set_write(d[0], W_LONG, 1'b0);
        add_row(8'h00, 8'h00, d[0], d[0], C_SD);
        set_write(d[1], W_LONG, 1'b1);
        add_row(8'hF0, 8'hF0, d[1], d[1], C_SD);
        set_write(d[2], W_WORD, 1'b0);
        add_row(8'h10, 8'h10, {16'h0, d[2][15:0]}, {16'h0, d[2][15:0]}, C_SD);
        set_write(d[3], W_BYTE, 1'b1);
        add_row(8'hF4, 8'hF4, xiy, xiy, C_SD);
        set_write(d[4], W_BYTE, 1'b0);
        add_row(8'h00, 8'h02, xwa0, 32'h0, C_SRC);
        set_write(d[5], W_WORD, 1'b1);
        add_row(8'hF8, 8'hF8, xiz, xiz, C_SD);
        set_write(d[5], W_LONG, 1'b0);
        cur.flag_only = 1'b1;
        add_row(8'h00, 8'h00, xwa0, xwa0, C_SD);
        // bank-relative codes while rfp moves
        set_write(d[6], W_LONG, 1'b0);
        add_row(8'h08, 8'hE8, d[6], d[6], C_SD);
        cur.inc_rfp = 1'b1;
        cur.e_rfp   = 2'd1;
        add_row(8'hE8, 8'hD8, 32'h0, d[6], C_SD | C_RFP);
        set_write(d[7], W_LONG, 1'b0);
        add_row(8'h10, 8'hE0, d[7], d[7], C_SD);
        cur.rfp_we  = 1'b1;
        cur.imm     = 2'd2;
        cur.inc_rfp = 1'b1;
        cur.e_rfp   = 2'd2;
        add_row(8'hD0, 8'hE0, d[7], 32'h0, C_SD | C_RFP);
        cur.dec_rfp = 1'b1;
        cur.inc_rfp = 1'b1;
        cur.e_rfp   = 2'd1;
        add_row(8'hE0, 8'hD8, d[7], d[6], C_SD | C_RFP);
        cur.dec_rfp = 1'b1;
        cur.e_rfp   = 2'd0;
        add_row(8'hE0, 8'hD0, xwa0, 32'h0, C_SD | C_RFP);
        cur.dec_rfp = 1'b1;
        cur.e_rfp   = 2'd3;
        add_row(8'h00, 8'hE0, xwa0, 32'h0, C_SD | C_RFP);
        set_write(d[8], W_LONG, 1'b0);
        add_row(8'h34, 8'hE4, d[8], d[8], C_SD);
        cur.rfp_we = 1'b1;
        cur.e_rfp  = 2'd0;
        add_row(8'hD4, 8'h34, d[8], d[8], C_SD | C_RFP);
        // BC countdown with the unity flag and the XDE/XHL block decrement
        set_write(32'h0000_0003, W_WORD, 1'b0);
        add_row(8'h04, 8'hE4, 32'd3, 32'd3, C_SD | C_UNI);
        cur.dec_bc = 1'b1;
        add_row(8'h04, 8'h04, 32'd2, 32'd2, C_SD | C_UNI);
        cur.dec_bc = 1'b1;
        add_row(8'h04, 8'h04, 32'd1, 32'd1, C_SD | C_UNI);
        cur.e_unity = 1'b1;
        add_row(8'h04, 8'h04, 32'd1, 32'd1, C_SD | C_UNI);
        cur.dec_bc  = 1'b1;
        cur.e_unity = 1'b1;
        add_row(8'h04, 8'h04, 32'd0, 32'd0, C_SD | C_UNI);
        set_write(d[9], W_LONG, 1'b0);
        add_row(8'h0C, 8'h0C, d[9], d[9], C_SD | C_UNI);
        cur.xdehl_dec = 1'b1;
        cur.reg_step  = 2'd1;
        add_row(8'hE8, 8'hEC, d[6] - 32'd2, d[9] - 32'd2, C_SD);
        cur.xdehl_dec = 1'b1;
        cur.reg_step  = 2'd2;
        add_row(8'h08, 8'h0C, d[6] - 32'd6, d[9] - 32'd6, C_SD);
        // index stepping and stack adjust
        cur.reg_inc = 1'b1;
        add_row(8'hF0, 8'hF0, d[1] + 32'd1, d[1] + 32'd1, C_SD);
        cur.reg_inc  = 1'b1;
        cur.reg_step = 2'd2;
        add_row(8'hF0, 8'hF0, d[1] + 32'd5, d[1] + 32'd5, C_SD);
        cur.reg_dec  = 1'b1;
        cur.reg_step = 2'd1;
        add_row(8'hF0, 8'hF4, xix, xiy - 32'd2, C_SD);
        add_row(8'hF0, 8'hF4, xix, xiy, C_SD);
        cur.inc_xsp = 3'd4;
        cur.e_xsp   = 32'd4;
        add_row(8'hFC, 8'hFC, 32'd4, 32'd4, C_SD | C_XSP);
        cur.dec_xsp = 3'd1;
        cur.e_xsp   = 32'd3;
        add_row(8'hFC, 8'hFC, 32'd3, 32'd3, C_SD | C_XSP);
        cur.inc_xsp = 3'd3;
        cur.dec_xsp = 3'd2;
        cur.e_xsp   = 32'd6;
        add_row(8'hFC, 8'hFC, 32'd6, 32'd6, C_SD | C_XSP);
        cur.dec_xsp = 3'd7;
        cur.e_xsp   = 32'hFFFF_FFFF;
        add_row(8'hFC, 8'hFC, 32'hFFFF_FFFF, 32'hFFFF_FFFF, C_SD | C_XSP);
        // zero code, aux operand and index register selection
        add_row(8'h40, 8'h00, 32'h0, xwa0, C_SD | C_AUX);
        cur.e_aux = d[6] - 32'd6;
        add_row(8'h0C, 8'h00, d[9] - 32'd6, xwa0, C_SD | C_AUX);
        cur.e_aux = xiz;
        add_row(8'hFC, 8'hF4, 32'hFFFF_FFFF, xiy, C_SD | C_AUX);
        cur.idx_en        = 1'b1;
        cur.idx_rdreg_sel = 8'hF0;
        cur.idx_rdreg_aux = 8'hE8;
        add_row(8'h40, 8'h00, xix, d[6] - 32'd6, C_SD);
        // dump port reads one cycle after the address
        cur.dmp_addr = 8'h00;
        cur.e_dmp    = xwa0[7:0];
        add_row(8'h00, 8'h00, 32'h0, 32'h0, C_DMP);
        cur.dmp_addr = 8'h37;
        cur.e_dmp    = d[8][31:24];
        add_row(8'h00, 8'h00, 32'h0, 32'h0, C_DMP);
        // cen low holds every register while the dump keeps running
        set_write(d[10], W_LONG, 1'b0);
        cur.hold     = 1'b1;
        cur.inc_rfp  = 1'b1;
        cur.dec_bc   = 1'b1;
        cur.inc_xsp  = 3'd1;
        cur.e_xsp    = 32'hFFFF_FFFF;
        cur.dmp_addr = 8'h41;
        cur.e_dmp    = xix[15:8];
        add_row(8'h00, 8'h04, xwa0, 32'h0, C_SD | C_XSP | C_DMP | C_RFP);
        cur.dmp_addr = 8'h4F;
        cur.e_dmp    = 8'hFF;
        add_row(8'h00, 8'h00, 32'h0, 32'h0, C_DMP);
        cur.dmp_addr = 8'h50;
        cur.sr       = d[10][15:0];
        cur.e_dmp    = d[10][15:8];
        add_row(8'h00, 8'h00, 32'h0, 32'h0, C_DMP);
        cur.dmp_addr = 8'h51;
        cur.sr       = d[10][15:0];
        cur.e_dmp    = d[10][7:0];
        add_row(8'h00, 8'h00, 32'h0, 32'h0, C_DMP);
    endtask

    initial begin
        int rst_wait;
        n_rows   = 0;
        n_checks = 0;
        n_errors = 0;
        seed     = 25476;
        drive_row('0);
        build_table();
        rst_wait = 0;
        while (rst !== 1'b0 && rst_wait < RST_TIMEOUT) begin
            @(posedge clk);
            rst_wait++;
        end
        if (rst !== 1'b0) begin
            $display("timeout: reset was not released within %0d cycles", RST_TIMEOUT);
            $display("TESTS FAILED");
        end else begin
            #DRIVE_DLY;
            drive_row(tbl[0]);
            for (int r = 0; r < n_rows; r++) begin
                @(posedge clk);
                #SAMPLE_DLY;
                check_row(r);
                #(DRIVE_DLY - SAMPLE_DLY);
                drive_row(r + 1 < n_rows ? tbl[r + 1] : row_t'('0));
            end
            $display("%0d checks, %0d errors", n_checks, n_errors);
            if (n_errors == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
        end
        $finish;
    end

endmodule

//--- logic/regs_top.sv
// general register block top, joins the accumulator file, pointer file and operand selector
`timescale 1ns/100ps

module regs_top
    import reg_types_pkg::*, access_pkg::*;
(
    input  logic       rst,
    input  logic       clk,
    input  logic       cen,
    input  word_t      sr,
    output bank_t      rfp,
    input  logic       inc_rfp,
    input  logic       dec_rfp,
    input  logic       rfp_we,
    input  bank_t      imm,
    output logic       bc_unity,
    input  logic       dec_bc,
    output long_t      xsp,
    input  logic [2:0] inc_xsp,
    input  logic [2:0] dec_xsp,
    input  reg_code_t  idx_rdreg_sel,
    input  step_t      reg_step,
    input  logic       xdehl_dec,
    input  logic       reg_inc,
    input  logic       reg_dec,
    input  reg_code_t  idx_rdreg_aux,
    input  logic       idx_en,
    input  long_t      alu_dout,
    input  long_t      ram_dout,
    input  logic       data_sel,
    input  reg_code_t  src,
    output long_t      src_out,
    output long_t      aux_out,
    input  reg_code_t  dst,
    output long_t      dst_out,
    input  size_t      ram_we,
    input  size_t      alu_we,
    input  logic       flag_only,
    input  byte_t      dmp_addr,
    output byte_t      dmp_din
);

    acc_addr_t  acc_rd_src_addr, acc_rd_aux_addr, acc_rd_dst_addr, acc_wr_addr;
    ptr_addr_t  ptr_rd_src_addr, ptr_rd_aux_addr, ptr_rd_dst_addr, ptr_wr_addr;
    long_t      acc_rd_src, acc_rd_aux, acc_rd_dst;
    long_t      ptr_rd_src, ptr_rd_aux, ptr_rd_dst;
    size_t      acc_wr_size, ptr_wr_size;
    long_t      wr_data;
    logic [5:0] dmp_idx;
    byte_t      acc_dmp_byte, ptr_dmp_byte;

    bank_file i_bank_file (
        .clk, .rst, .cen, .inc_rfp, .dec_rfp, .rfp_we, .imm, .rfp,
        .dec_bc, .xdehl_dec, .reg_step, .bc_unity,
        .rd_src_addr (acc_rd_src_addr), .rd_aux_addr (acc_rd_aux_addr),
        .rd_dst_addr (acc_rd_dst_addr),
        .rd_src (acc_rd_src), .rd_aux (acc_rd_aux), .rd_dst (acc_rd_dst),
        .wr_addr (acc_wr_addr), .wr_size (acc_wr_size), .wr_data,
        .dmp_idx, .dmp_byte (acc_dmp_byte)
    );

    ptr_file i_ptr_file (
        .clk, .rst, .cen,
        .rd_src_addr (ptr_rd_src_addr), .rd_aux_addr (ptr_rd_aux_addr),
        .rd_dst_addr (ptr_rd_dst_addr),
        .rd_src (ptr_rd_src), .rd_aux (ptr_rd_aux), .rd_dst (ptr_rd_dst),
        .reg_inc, .reg_dec, .reg_step, .inc_xsp, .dec_xsp, .xsp,
        .wr_addr (ptr_wr_addr), .wr_size (ptr_wr_size), .wr_data,
        .dmp_idx (dmp_idx[3:0]), .dmp_byte (ptr_dmp_byte)
    );

    operand_select i_operand_select (
        .rfp, .src, .dst, .idx_rdreg_sel, .idx_rdreg_aux, .idx_en, .reg_dec, .reg_step,
        .acc_rd_src_addr, .acc_rd_aux_addr, .acc_rd_dst_addr,
        .ptr_rd_src_addr, .ptr_rd_aux_addr, .ptr_rd_dst_addr,
        .acc_rd_src, .acc_rd_aux, .acc_rd_dst, .ptr_rd_src, .ptr_rd_aux, .ptr_rd_dst,
        .src_out, .aux_out, .dst_out,
        .alu_dout, .ram_dout, .data_sel, .flag_only, .alu_we, .ram_we,
        .acc_wr_addr, .ptr_wr_addr, .acc_wr_size, .ptr_wr_size, .wr_data,
        .clk, .dmp_addr, .sr, .acc_dmp_byte, .ptr_dmp_byte, .dmp_idx, .dmp_din
    );

endmodule

//--- logic/operand_select.sv
// register code decoding, operand muxing, write routing and the dump byte register
`timescale 1ns/100ps
`include "regs_defines.svh"

module operand_select
    import reg_types_pkg::*, access_pkg::*;
(
    input  bank_t      rfp,
    input  reg_code_t  src,
    input  reg_code_t  dst,
    input  reg_code_t  idx_rdreg_sel,
    input  reg_code_t  idx_rdreg_aux,
    input  logic       idx_en,
    input  logic       reg_dec,
    input  step_t      reg_step,
    output acc_addr_t  acc_rd_src_addr,
    output acc_addr_t  acc_rd_aux_addr,
    output acc_addr_t  acc_rd_dst_addr,
    output ptr_addr_t  ptr_rd_src_addr,
    output ptr_addr_t  ptr_rd_aux_addr,
    output ptr_addr_t  ptr_rd_dst_addr,
    input  long_t      acc_rd_src,
    input  long_t      acc_rd_aux,
    input  long_t      acc_rd_dst,
    input  long_t      ptr_rd_src,
    input  long_t      ptr_rd_aux,
    input  long_t      ptr_rd_dst,
    output long_t      src_out,
    output long_t      aux_out,
    output long_t      dst_out,
    input  long_t      alu_dout,
    input  long_t      ram_dout,
    input  logic       data_sel,
    input  logic       flag_only,
    input  size_t      alu_we,
    input  size_t      ram_we,
    output acc_addr_t  acc_wr_addr,
    output ptr_addr_t  ptr_wr_addr,
    output size_t      acc_wr_size,
    output size_t      ptr_wr_size,
    output long_t      wr_data,
    input  logic       clk,
    input  byte_t      dmp_addr,
    input  word_t      sr,
    input  byte_t      acc_dmp_byte,
    input  byte_t      ptr_dmp_byte,
    output logic [5:0] dmp_idx,
    output byte_t      dmp_din
);

    reg_code_t src_sel;
    reg_code_t aux_sel;
    reg_code_t dst_sel;
    size_t     wr_size;

    // map current/previous bank codes onto an explicit bank
    function automatic reg_code_t resolve(input bank_t cur, input reg_code_t code);
        reg_code_t res;
        res = code;
        if (code[7:4] == `CUR_BANK_NIB) begin
            res[7:4] = {2'b00, cur};
        end else if (code[7:4] == `PREV_BANK_NIB) begin
            res[7:4] = {2'b00, bank_t'(cur - 2'd1)};
        end
        return res;
    endfunction

    always_comb begin
        src_sel = resolve(rfp, idx_en ? idx_rdreg_sel : src);
        dst_sel = resolve(rfp, idx_en ? idx_rdreg_aux : dst);
        // second index register of two-pointer instructions
        aux_sel = src_sel & ~8'h04;
    end

    always_comb begin
        acc_rd_src_addr = src_sel[5:0];
        acc_rd_aux_addr = aux_sel[5:0];
        acc_rd_dst_addr = dst_sel[5:0];
        ptr_rd_src_addr = src_sel[3:0];
        ptr_rd_aux_addr = aux_sel[3:0];
        ptr_rd_dst_addr = dst_sel[3:0];
    end

    // bit 7 picks the pointer file
    always_comb begin
        if (src_sel[7:4] == `ZERO_NIB) begin
            src_out = '0;
        end else begin
            src_out = src_sel[7] ? ptr_rd_src : acc_rd_src;
        end
        if (aux_sel[7:4] == `ZERO_NIB) begin
            aux_out = '0;
        end else begin
            aux_out = aux_sel[7] ? ptr_rd_aux : acc_rd_aux;
        end
        dst_out = dst_sel[7] ? ptr_rd_dst : acc_rd_dst;
        // pre-decrement view of the destination
        if (reg_dec) begin
            dst_out = dst_out - step_bytes(reg_step);
        end
    end

    // result write routing
    always_comb begin
        wr_data     = data_sel ? ram_dout : alu_dout;
        wr_size     = flag_only ? 3'b000 : (data_sel ? ram_we : alu_we);
        acc_wr_addr = dst_sel[5:0];
        ptr_wr_addr = dst_sel[3:0];
        acc_wr_size = dst_sel[7] ? 3'b000 : wr_size;
        ptr_wr_size = dst_sel[7] ? wr_size : 3'b000;
    end

    assign dmp_idx = dmp_addr[5:0];

    // debug dump, runs off the raw clock
    always_ff @(posedge clk) begin
        if (dmp_addr < `DMP_PTR_BASE) begin
            dmp_din <= acc_dmp_byte;
        end else if (dmp_addr < `DMP_SR_HI) begin
            dmp_din <= ptr_dmp_byte;
        end else if (dmp_addr == `DMP_SR_HI) begin
            dmp_din <= sr[15:8];
        end else if (dmp_addr == `DMP_SR_LO) begin
            dmp_din <= sr[7:0];
        end else begin
            dmp_din <= '0;
        end
    end

endmodule

//--- logic/ptr_file.sv
// pointer array XIX/XIY/XIZ/XSP with index stepping, stack adjust and sized writes
`timescale 1ns/100ps
`include "regs_defines.svh"

module ptr_file
    import reg_types_pkg::*, access_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    input  ptr_addr_t rd_src_addr,
    input  ptr_addr_t rd_aux_addr,
    input  ptr_addr_t rd_dst_addr,
    output long_t     rd_src,
    output long_t     rd_aux,
    output long_t     rd_dst,
    input  logic      reg_inc,
    input  logic      reg_dec,
    input  step_t     reg_step,
    input  logic [2:0] inc_xsp,
    input  logic [2:0] dec_xsp,
    output long_t     xsp,
    input  ptr_addr_t wr_addr,
    input  size_t     wr_size,
    input  long_t     wr_data,
    input  ptr_addr_t dmp_idx,
    output byte_t     dmp_byte
);

    byte_t ptrs [`PTR_BYTES];

    long_t src_ptr;
    long_t step;

    function automatic long_t read_long(input ptr_addr_t a);
        return {ptrs[{a[3:2], 2'b11}], ptrs[{a[3:2], 2'b10}],
                ptrs[{a[3:1], 1'b1}], ptrs[a]};
    endfunction

    always_comb begin
        rd_src   = read_long(rd_src_addr);
        rd_aux   = read_long(rd_aux_addr);
        rd_dst   = read_long(rd_dst_addr);
        dmp_byte = ptrs[dmp_idx];
    end

    // whole 32-bit pointer named by the source code, and the stack pointer
    always_comb begin
        src_ptr = read_long({rd_src_addr[3:2], 2'b00});
        xsp     = read_long(4'hc);
        step    = step_bytes(reg_step);
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PTR_BYTES; i++) begin
                ptrs[i] <= '0;
            end
        end else if (cen) begin
            // post-increment / pre-decrement addressing
            if (reg_inc) begin
                for (int i = 0; i < 4; i++) begin
                    ptrs[{rd_src_addr[3:2], 2'(i)}] <= byte_t'((src_ptr + step) >> (8 * i));
                end
            end
            if (reg_dec) begin
                for (int i = 0; i < 4; i++) begin
                    ptrs[{rd_src_addr[3:2], 2'(i)}] <= byte_t'((src_ptr - step) >> (8 * i));
                end
            end

            // push and pop, increment has priority
            if (inc_xsp != 3'd0) begin
                for (int i = 0; i < 4; i++) begin
                    ptrs[{2'b11, 2'(i)}] <= byte_t'((xsp + {29'd0, inc_xsp}) >> (8 * i));
                end
            end else if (dec_xsp != 3'd0) begin
                for (int i = 0; i < 4; i++) begin
                    ptrs[{2'b11, 2'(i)}] <= byte_t'((xsp - {29'd0, dec_xsp}) >> (8 * i));
                end
            end

            // register writes last so they take the byte
            if (wr_size[SZ_LONG_BIT]) begin
                for (int i = 0; i < 4; i++) begin
                    ptrs[{wr_addr[3:2], 2'(i)}] <= wr_data[8*i +: 8];
                end
            end
            if (wr_size[SZ_WORD_BIT]) begin
                ptrs[{wr_addr[3:1], 1'b1}] <= wr_data[15:8];
                ptrs[wr_addr]              <= wr_data[7:0];
            end
            if (wr_size[SZ_BYTE_BIT]) begin
                ptrs[wr_addr] <= wr_data[7:0];
            end
        end
    end

endmodule

//--- logic/bank_file.sv
// banked accumulator array with rfp, block decrements of BC/XDE/XHL and the BC unity flag
`timescale 1ns/100ps
`include "regs_defines.svh"

module bank_file
    import reg_types_pkg::*, access_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    input  logic      inc_rfp,
    input  logic      dec_rfp,
    input  logic      rfp_we,
    input  bank_t     imm,
    output bank_t     rfp,
    input  logic      dec_bc,
    input  logic      xdehl_dec,
    input  step_t     reg_step,
    output logic      bc_unity,
    input  acc_addr_t rd_src_addr,
    input  acc_addr_t rd_aux_addr,
    input  acc_addr_t rd_dst_addr,
    output long_t     rd_src,
    output long_t     rd_aux,
    output long_t     rd_dst,
    input  acc_addr_t wr_addr,
    input  size_t     wr_size,
    input  long_t     wr_data,
    input  acc_addr_t dmp_idx,
    output byte_t     dmp_byte
);

    byte_t accs [`ACC_BYTES];

    word_t cur_bc;
    long_t cur_xde;
    long_t cur_xhl;
    long_t step;

    // lane 0 at the exact address, lane 1 at the odd byte, upper half aligned
    function automatic long_t read_long(input acc_addr_t a);
        return {accs[{a[5:2], 2'b11}], accs[{a[5:2], 2'b10}],
                accs[{a[5:1], 1'b1}], accs[a]};
    endfunction

    always_comb begin
        rd_src   = read_long(rd_src_addr);
        rd_aux   = read_long(rd_aux_addr);
        rd_dst   = read_long(rd_dst_addr);
        dmp_byte = accs[dmp_idx];
    end

    // current bank views used by block instructions
    always_comb begin
        cur_bc  = {accs[{rfp, 4'h5}], accs[{rfp, 4'h4}]};
        cur_xde = read_long({rfp, 4'h8});
        cur_xhl = read_long({rfp, 4'hc});
        step    = step_bytes(reg_step);
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ACC_BYTES; i++) begin
                accs[i] <= '0;
            end
            bc_unity <= 1'b0;
        end else if (cen) begin
            bc_unity <= (cur_bc == 16'd1);

            // block instruction counters
            if (dec_bc) begin
                accs[{rfp, 4'h4}] <= byte_t'(cur_bc - 16'd1);
                accs[{rfp, 4'h5}] <= byte_t'((cur_bc - 16'd1) >> 8);
            end
            if (xdehl_dec) begin
                for (int i = 0; i < 4; i++) begin
                    accs[{rfp, 2'b10, 2'(i)}] <= byte_t'((cur_xde - step) >> (8 * i));
                    accs[{rfp, 2'b11, 2'(i)}] <= byte_t'((cur_xhl - step) >> (8 * i));
                end
            end

            // ALU or memory result, placed last so it overrides the counters
            if (wr_size[SZ_LONG_BIT]) begin
                for (int i = 0; i < 4; i++) begin
                    accs[{wr_addr[5:2], 2'(i)}] <= wr_data[8*i +: 8];
                end
            end
            if (wr_size[SZ_WORD_BIT]) begin
                accs[{wr_addr[5:1], 1'b1}] <= wr_data[15:8];
                accs[wr_addr]              <= wr_data[7:0];
            end
            if (wr_size[SZ_BYTE_BIT]) begin
                accs[wr_addr] <= wr_data[7:0];
            end
        end
    end

    // load beats decrement, decrement beats increment
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rfp <= '0;
        end else if (cen) begin
            if (rfp_we) begin
                rfp <= imm;
            end else if (dec_rfp) begin
                rfp <= rfp - 2'd1;
            end else if (inc_rfp) begin
                rfp <= rfp + 2'd1;
            end
        end
    end

endmodule

//--- logic/access_pkg.sv
// access size one-hot, step code and step-to-byte-count function
package access_pkg;
    import reg_types_pkg::*;

    // one-hot write width
    typedef logic [2:0] size_t;

    // bit positions inside size_t
    localparam int SZ_BYTE_BIT = 0;
    localparam int SZ_WORD_BIT = 1;
    localparam int SZ_LONG_BIT = 2;

    // pointer step code: 0 = 1 byte, 1 = 2 bytes, 2 = 4 bytes
    typedef logic [1:0] step_t;

    // byte increment for a step code
    // code 3 is not used and falls back to one byte
    function automatic long_t step_bytes(input step_t step);
        long_t inc;
        case (step)
            2'd1: inc = 32'd2;
            2'd2: inc = 32'd4;
            default: inc = 32'd1;
        endcase
        return inc;
    endfunction

endpackage

//--- logic/reg_types_pkg.sv
// data, register code and register address types
package reg_types_pkg;

    // data widths
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [31:0] long_t;

    // 8-bit register code as found in the instruction
    typedef logic [7:0]  reg_code_t;

    // register file pointer, selects one of four banks
    typedef logic [1:0]  bank_t;

    // byte address in the banked accumulator array
    // upper two bits are the bank
    typedef logic [5:0]  acc_addr_t;

    // byte address in the pointer array
    typedef logic [3:0]  ptr_addr_t;

endpackage

//--- include/regs_defines.svh
// register code nibbles, dump address map and array sizes for the register block
`ifndef REGS_DEFINES_SVH
`define REGS_DEFINES_SVH

// upper nibble of bank-relative register codes
`define CUR_BANK_NIB  4'hE
`define PREV_BANK_NIB 4'hD

// upper nibble that reads as constant zero
`define ZERO_NIB      4'h4

// byte counts of the two register arrays
// 4 banks x 16 bytes
`define ACC_BYTES     64
// XIX, XIY, XIZ, XSP
`define PTR_BYTES     16

// dump address map
// accumulators occupy 00-3f, pointers 40-4f
`define DMP_PTR_BASE  8'h40
`define DMP_SR_HI     8'h50
`define DMP_SR_LO     8'h51

`endif
